/* verilog/beeb_mem_cfg.svh */
// memory system widths, array depths, rom bank count and credit limits
`ifndef BEEB_MEM_CFG_SVH
`define BEEB_MEM_CFG_SVH

// ========================================================================
// address map
// ========================================================================

// core byte address, bit 18 picks ram
`define MEM_ADDR_BITS 19
// byte offset inside one 16 KB rom slot
`define ROM_OFS_BITS 14
// physical rom banks behind the slot remap
`define ROM_BANKS 14
// rom load port addresses 16-bit words
`define ROM_WORD_BITS 17
// main, shadow and sideways ram bytes
`define RAM_DEPTH 212992

// ========================================================================
// flow control
// ========================================================================

// request queue entries, also the requester's starting credits
`define REQ_DEPTH 4
// read data buffer entries
`define RESP_DEPTH 4
`define CREDIT_BITS 3

`endif

/* verilog/mem_map_pkg.sv */
// address union with ram and rom views, machine model enum, rom bank index
`default_nettype none

package mem_map_pkg;

	`include "beeb_mem_cfg.svh"

	// ====================================================================
	// core address decode
	// ====================================================================

	// one core address seen two ways
	// is_ram set selects the ram view, clear selects the rom view
	typedef union packed {
		struct packed {
			logic                            is_ram;
			logic [`MEM_ADDR_BITS-2:0]       ofs;
		} ram;
		struct packed {
			logic                                       is_ram;
			// sixteen logical 16 KB slots
			logic [`MEM_ADDR_BITS-`ROM_OFS_BITS-2:0]    slot;
			logic [`ROM_OFS_BITS-1:0]                   ofs;
		} rom;
	} mem_addr_u;

	// model picks the slot remap table
	typedef enum logic {
		model_b      = 1'b0,
		model_master = 1'b1
	} machine_model_e;

	// physical bank, 0..13 in use
	typedef logic [$clog2(`ROM_BANKS)-1:0] rom_bank_t;

endpackage

`default_nettype wire

/* verilog/bus_pkg.sv */
// request kind enum, credit counter type, request queue pointer type
`default_nettype none

package bus_pkg;

	`include "beeb_mem_cfg.svh"

	// one bit is enough, no other transaction kinds
	typedef enum logic {
		req_read  = 1'b0,
		req_write = 1'b1
	} req_kind_e;

	// credits held and queue occupancy
	typedef logic [`CREDIT_BITS-1:0] credit_t;

	// wraps naturally, depth is a power of two
	typedef logic [$clog2(`REQ_DEPTH)-1:0] queue_idx_t;

endpackage

`default_nettype wire

/* verilog/req_queue.sv */
// credited request queue feeding the access stage, returns one credit per pop
`default_nettype none
`timescale 1ns/100ps

`include "beeb_mem_cfg.svh"

module req_queue import bus_pkg::*, mem_map_pkg::*; (
	input  wire             clk_sys,
	input  wire             reset,
	input  wire             req_valid,
	input  wire req_kind_e  req_kind,
	input  wire mem_addr_u  req_addr,
	input  wire [7:0]       req_wdata,
	input  wire             issue_ready,
	output logic            issue_valid,
	output req_kind_e       issue_kind,
	output mem_addr_u       issue_addr,
	output logic [7:0]      issue_wdata,
	output logic            req_credit
);

	localparam credit_t DEPTH_C = credit_t'(`REQ_DEPTH);

	// entry storage, payload only
	req_kind_e  kind_mem [`REQ_DEPTH];
	mem_addr_u  addr_mem [`REQ_DEPTH];
	logic [7:0] data_mem [`REQ_DEPTH];

	queue_idx_t wr_ptr;
	queue_idx_t rd_ptr;
	credit_t    count;
	logic       pop;

	// head is always presented
	assign issue_valid = (count != '0);
	assign issue_kind  = kind_mem[rd_ptr];
	assign issue_addr  = addr_mem[rd_ptr];
	assign issue_wdata = data_mem[rd_ptr];
	assign pop         = issue_valid && issue_ready;

	always_ff @(posedge clk_sys) begin
		if (req_valid) begin
			kind_mem[wr_ptr] <= req_kind;
			addr_mem[wr_ptr] <= req_addr;
			data_mem[wr_ptr] <= req_wdata;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			req_credit <= 1'b0;
		end else begin
			if (req_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + credit_t'(req_valid) - credit_t'(pop);
			// credit goes back the cycle after the pop
			req_credit <= pop;
		end
	end

	// requester may only send while it holds a credit
	// so a full queue means it pushed without one
	a_push_credit : assert property (@(posedge clk_sys) disable iff (reset)
		req_valid |-> (count != DEPTH_C))
		else $error("request pushed into full queue, requester out of credit");

endmodule

`default_nettype wire

/* verilog/rom_bank_map.sv */
// machine model latch and rom slot to physical bank remap
`default_nettype none
`timescale 1ns/100ps

`include "beeb_mem_cfg.svh"

module rom_bank_map import mem_map_pkg::*; (
	input  wire                  clk_sys,
	input  wire                  reset,
	input  wire machine_model_e  model,
	input  wire [3:0]            slot,
	output rom_bank_t            bank,
	output logic                 bank_hit
);

	machine_model_e model_q;

	// model only changes while reset is held
	always_ff @(posedge clk_sys) begin
		if (reset)
			model_q <= model;
	end

	// ========================================================================
	// slot remap
	// ========================================================================

	always_comb begin
		bank     = '0;
		bank_hit = 1'b0;
		if (model_q == model_b) begin
			// os, filing system, ram utility, basic
			case (slot)
				4'd4:    begin bank = 4'd0; bank_hit = 1'b1; end
				4'd8:    begin bank = 4'd1; bank_hit = 1'b1; end
				4'd14:   begin bank = 4'd2; bank_hit = 1'b1; end
				4'd15:   begin bank = 4'd3; bank_hit = 1'b1; end
				default: begin bank = '0;   bank_hit = 1'b0; end
			endcase
		end else begin
			// master banks sit after the four model b banks
			if (slot == 4'd2 || slot == 4'd3) begin
				bank     = slot + 4'd2;
				bank_hit = 1'b1;
			end else if (slot == 4'd4) begin
				bank     = 4'd6;
				bank_hit = 1'b1;
			end else if (slot >= 4'd9) begin
				// 9..15 packed down onto 7..13
				bank     = slot - 4'd2;
				bank_hit = 1'b1;
			end
		end
	end

	a_bank_range : assert property (@(posedge clk_sys) disable iff (reset)
		bank_hit |-> (bank < 4'(`ROM_BANKS)))
		else $error("rom slot %0d mapped past last bank %0d", slot, bank);

endmodule

`default_nettype wire

/* verilog/beeb_mem_access.sv */
// rom and ram arrays, rom load port, write commit and two-stage read pipeline
`default_nettype none
`timescale 1ns/100ps

`include "beeb_mem_cfg.svh"

module beeb_mem_access import bus_pkg::*, mem_map_pkg::*; (
	input  wire                       clk_sys,
	input  wire                       reset,
	input  wire                       issue_valid,
	input  wire req_kind_e            issue_kind,
	input  wire mem_addr_u            issue_addr,
	input  wire [7:0]                 issue_wdata,
	input  wire                       load_wr,
	input  wire [`ROM_WORD_BITS-1:0]  load_addr,
	input  wire [15:0]                load_data,
	input  wire machine_model_e       model,
	input  wire                       buf_ready,
	output logic                      rd_issue,
	output logic                      rd_done,
	output logic [7:0]                rd_data
);

	localparam int ROM_WORDS = `ROM_BANKS << (`ROM_OFS_BITS - 1);

	logic [15:0] rom_mem [ROM_WORDS];
	logic [7:0]  ram_mem [`RAM_DEPTH];

	rom_bank_t                 bank;
	logic                      bank_hit;
	logic                      wr_accept;
	logic [`ROM_WORD_BITS-1:0] rom_rd_addr;

	// stage 1, array outputs and decode
	logic        s1_rd;
	logic        s1_is_ram;
	logic        s1_lsb;
	logic        s1_hit;
	logic [15:0] rom_q;
	logic [7:0]  ram_q;

	rom_bank_map i_rom_bank_map (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.model    (model),
		.slot     (issue_addr.rom.slot),
		.bank     (bank),
		.bank_hit (bank_hit)
	);

	// same handshake the queue pops on
	assign rd_issue  = issue_valid && buf_ready && (issue_kind == req_read);
	assign wr_accept = issue_valid && buf_ready && (issue_kind == req_write);
	// word address, byte lane dropped
	assign rom_rd_addr = {bank, issue_addr.rom.ofs[`ROM_OFS_BITS-1:1]};

	// download words arrive little endian, stored swapped
	always_ff @(posedge clk_sys) begin
		if (reset && load_wr)
			rom_mem[load_addr] <= {load_data[7:0], load_data[15:8]};
	end

	always_ff @(posedge clk_sys) begin
		if (rd_issue)
			rom_q <= rom_mem[rom_rd_addr];
	end

	// writes into rom space are dropped
	always_ff @(posedge clk_sys) begin
		if (wr_accept && issue_addr.ram.is_ram)
			ram_mem[issue_addr.ram.ofs] <= issue_wdata;
		if (rd_issue)
			ram_q <= ram_mem[issue_addr.ram.ofs];
	end

	always_ff @(posedge clk_sys) begin
		if (rd_issue) begin
			s1_is_ram <= issue_addr.ram.is_ram;
			s1_lsb    <= issue_addr.rom.ofs[0];
			s1_hit    <= bank_hit;
		end
	end

	// stage 2, byte select into the output buffer
	always_ff @(posedge clk_sys) begin
		if (s1_is_ram)
			rd_data <= ram_q;
		else if (!s1_hit)
			rd_data <= 8'h00;
		else
			rd_data <= s1_lsb ? rom_q[7:0] : rom_q[15:8];
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			s1_rd   <= 1'b0;
			rd_done <= 1'b0;
		end else begin
			s1_rd   <= rd_issue;
			rd_done <= s1_rd;
		end
	end

endmodule

`default_nettype wire

/* verilog/resp_credit_out.sv */
// read data buffer with slot reservation, sent only against consumer credits
`default_nettype none
`timescale 1ns/100ps

`include "beeb_mem_cfg.svh"

module resp_credit_out import bus_pkg::*; (
	input  wire        clk_sys,
	input  wire        reset,
	input  wire        rd_issue,
	input  wire        rd_done,
	input  wire [7:0]  rd_data,
	input  wire        resp_credit,
	output logic       buf_ready,
	output logic       resp_valid,
	output logic [7:0] resp_data
);

	localparam int            PTR_BITS = $clog2(`RESP_DEPTH);
	localparam int            CNT_BITS = PTR_BITS + 1;
	localparam [CNT_BITS-1:0] DEPTH_C  = CNT_BITS'(`RESP_DEPTH);

	logic [7:0]          buf_mem [`RESP_DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	// entries held and reads still in the pipeline
	logic [CNT_BITS-1:0] count;
	logic [CNT_BITS-1:0] reserve;
	credit_t             credits;
	logic                send;

	// oldest entry leaves whenever a credit is held
	assign send       = (count != '0) && (credits != '0);
	assign resp_valid = send;
	assign resp_data  = buf_mem[rd_ptr];
	// in-flight reads already own their slot
	assign buf_ready  = (count + reserve) < DEPTH_C;

	always_ff @(posedge clk_sys) begin
		if (rd_done)
			buf_mem[wr_ptr] <= rd_data;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			reserve <= '0;
			credits <= '0;
		end else begin
			if (rd_done)
				wr_ptr <= wr_ptr + 1'b1;
			if (send)
				rd_ptr <= rd_ptr + 1'b1;
			count   <= count + CNT_BITS'(rd_done) - CNT_BITS'(send);
			reserve <= reserve + CNT_BITS'(rd_issue) - CNT_BITS'(rd_done);
			credits <= credits + credit_t'(resp_credit) - credit_t'(send);
		end
	end

	a_send_credit : assert property (@(posedge clk_sys) disable iff (reset)
		resp_valid |-> (credits != '0))
		else $error("response sent with no consumer credit");

	// every completing read must have reserved its slot at issue
	a_done_reserved : assert property (@(posedge clk_sys) disable iff (reset)
		rd_done |-> (reserve != '0))
		else $error("read completed without a buffer reservation");

endmodule

`default_nettype wire

/* verilog/beeb_mem_top.sv */
// memory system top, request queue to access stage to credited response buffer
`default_nettype none
`timescale 1ns/100ps

`include "beeb_mem_cfg.svh"

module beeb_mem_top import bus_pkg::*, mem_map_pkg::*; (
	input  wire                       clk_sys,
	input  wire                       reset,
	input  wire machine_model_e       model,
	// request side
	input  wire                       req_valid,
	input  wire req_kind_e            req_kind,
	input  wire mem_addr_u            req_addr,
	input  wire [7:0]                 req_wdata,
	output logic                      req_credit,
	// rom download, reset only
	input  wire                       load_wr,
	input  wire [`ROM_WORD_BITS-1:0]  load_addr,
	input  wire [15:0]                load_data,
	// response side
	input  wire                       resp_credit,
	output logic                      resp_valid,
	output logic [7:0]                resp_data
);

	logic       issue_valid;
	req_kind_e  issue_kind;
	mem_addr_u  issue_addr;
	logic [7:0] issue_wdata;
	// buffer space gates both the queue pop and the access stage
	logic       buf_ready;
	logic       rd_issue;
	logic       rd_done;
	logic [7:0] rd_data;

	req_queue i_req_queue (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.req_valid   (req_valid),
		.req_kind    (req_kind),
		.req_addr    (req_addr),
		.req_wdata   (req_wdata),
		.issue_ready (buf_ready),
		.issue_valid (issue_valid),
		.issue_kind  (issue_kind),
		.issue_addr  (issue_addr),
		.issue_wdata (issue_wdata),
		.req_credit  (req_credit)
	);

	beeb_mem_access i_beeb_mem_access (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.issue_valid (issue_valid),
		.issue_kind  (issue_kind),
		.issue_addr  (issue_addr),
		.issue_wdata (issue_wdata),
		.load_wr     (load_wr),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.model       (model),
		.buf_ready   (buf_ready),
		.rd_issue    (rd_issue),
		.rd_done     (rd_done),
		.rd_data     (rd_data)
	);

	resp_credit_out i_resp_credit_out (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.rd_issue    (rd_issue),
		.rd_done     (rd_done),
		.rd_data     (rd_data),
		.resp_credit (resp_credit),
		.buf_ready   (buf_ready),
		.resp_valid  (resp_valid),
		.resp_data   (resp_data)
	);

endmodule

`default_nettype wire

/* test/tb_beeb_mem.sv */
// testbench for beeb_mem_top, credited requester, reference memory model and checks
`default_nettype none
`timescale 1ns/100ps

`include "beeb_mem_cfg.svh"

module tb_beeb_mem import bus_pkg::*, mem_map_pkg::*; ();

	localparam int BANK_WORDS    = 1 << (`ROM_OFS_BITS - 1);
	localparam int RAM_OFS_W     = `MEM_ADDR_BITS - 1;
	localparam int SLOT_OFS_W    = `ROM_OFS_BITS;
	// words loaded per bank during reset
	localparam int WORDS_PER_BANK = 4;
	localparam int STALL_CYCLES  = 20;
	// request counts of tests 1 to 5
	localparam int REQ_TOTAL     = 56 + 92 + 38 + 10 + 60;
	localparam int RESET_CYCLES  = 2 * (20 + `ROM_BANKS * WORDS_PER_BANK);
	localparam int TIMEOUT_CYCLES = REQ_TOTAL * 12 + RESET_CYCLES + STALL_CYCLES + 500;

	logic                      clk_sys;
	logic                      reset;
	machine_model_e            model;
	logic                      req_valid;
	req_kind_e                 req_kind;
	mem_addr_u                 req_addr;
	logic [7:0]                req_wdata;
	logic                      req_credit;
	logic                      load_wr;
	logic [`ROM_WORD_BITS-1:0] load_addr;
	logic [15:0]               load_data;
	logic                      resp_credit;
	logic                      resp_valid;
	logic [7:0]                resp_data;

	// reference model
	logic [15:0] rom_model [int];
	logic [7:0]  ram_model [int];
	int          ram_list [$];
	int          word_ofs [`ROM_BANKS][WORDS_PER_BANK];
	logic [7:0]  exp_q [$];
	logic [7:0]  exp_byte;
	logic        cur_master;

	// requester and consumer bookkeeping
	int credits_held  = `REQ_DEPTH;
	int credit_pulses = 0;
	int req_sent      = 0;
	int reads_sent    = 0;
	int grants_given  = 0;
	int resp_seen     = 0;
	// 0 no grants, 1 grant when owed, 2 random grants
	int grant_mode    = 1;

	int errors       = 0;
	int checks       = 0;
	int tests_failed = 0;
	int cycle_count  = 0;
	int err_start;
	int i;
	int ofs;

	beeb_mem_top i_beeb_mem_top (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.model       (model),
		.req_valid   (req_valid),
		.req_kind    (req_kind),
		.req_addr    (req_addr),
		.req_wdata   (req_wdata),
		.req_credit  (req_credit),
		.load_wr     (load_wr),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.resp_credit (resp_credit),
		.resp_valid  (resp_valid),
		.resp_data   (resp_data)
	);

	always #20 clk_sys = ~clk_sys;

	// ========================================================================
	// checks
	// ========================================================================

	// every returned credit must match a request already sent
	a_credit_returned : assert property (@(posedge clk_sys) disable iff (reset)
		req_credit |-> (credit_pulses < req_sent))
		else begin
			$display("request credit returned with no request outstanding");
			errors = errors + 1;
		end

	// a response needs a grant that was not used yet
	a_resp_needs_grant : assert property (@(posedge clk_sys) disable iff (reset)
		resp_valid |-> (resp_seen <= grants_given))
		else begin
			$display("response sent without a consumer credit");
			errors = errors + 1;
		end

	// sampled mid cycle, outputs settled
	always @(negedge clk_sys) begin
		if (reset) begin
			resp_seen = 0;
		end else if (resp_valid) begin
			resp_seen = resp_seen + 1;
			if (exp_q.size() == 0) begin
				$display("response arrived with no read outstanding, data %h", resp_data);
				errors = errors + 1;
			end else begin
				exp_byte = exp_q.pop_front();
				checks = checks + 1;
				a_resp_data : assert (resp_data === exp_byte)
					else begin
						$display("[FAIL] resp_data got %h expected %h", resp_data, exp_byte);
						errors = errors + 1;
					end
			end
		end
	end

	always @(posedge clk_sys) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, run did not complete", cycle_count);
			$display("TEST FAIL");
			$finish;
		end
	end

	// ========================================================================
	// reference rules
	// ========================================================================

	// slot remap per model, -1 for no rom
	function automatic int map_slot(logic master, int slot);
		int b_tab [16];
		int m_tab [16];
		b_tab = '{-1, -1, -1, -1, 0, -1, -1, -1, 1, -1, -1, -1, -1, -1, 2, 3};
		m_tab = '{-1, -1, 4, 5, 6, -1, -1, -1, -1, 7, 8, 9, 10, 11, 12, 13};
		if (master)
			return m_tab[slot];
		return b_tab[slot];
	endfunction

	function automatic logic [7:0] rom_byte(logic master, int slot, int byte_ofs);
		int          bank;
		int          k;
		logic [15:0] w;
		bank = map_slot(master, slot);
		if (bank < 0)
			return 8'h00;
		k = bank * BANK_WORDS + byte_ofs / 2;
		w = rom_model[k];
		// even offset is the low byte of the loaded word
		if (byte_ofs % 2 == 0)
			return w[7:0];
		return w[15:8];
	endfunction

	function automatic mem_addr_u ram_addr(int ram_ofs);
		mem_addr_u a;
		a.ram.is_ram = 1'b1;
		a.ram.ofs    = RAM_OFS_W'(ram_ofs);
		return a;
	endfunction

	function automatic mem_addr_u rom_addr(int slot, int byte_ofs);
		mem_addr_u a;
		a.rom.is_ram = 1'b0;
		a.rom.slot   = 4'(slot);
		a.rom.ofs    = SLOT_OFS_W'(byte_ofs);
		return a;
	endfunction

	// ========================================================================
	// requester and consumer
	// ========================================================================

	// one clock, collects returned credits and hands out response grants
	task automatic tick();
		@(posedge clk_sys);
		if (req_credit === 1'b1) begin
			credits_held  = credits_held + 1;
			credit_pulses = credit_pulses + 1;
		end
		req_valid   <= 1'b0;
		load_wr     <= 1'b0;
		resp_credit <= 1'b0;
		// consumer has RESP_DEPTH slots of its own
		if (!reset && grants_given < reads_sent && grants_given - resp_seen < `RESP_DEPTH) begin
			if (grant_mode == 1 || (grant_mode == 2 && $urandom_range(0, 2) == 0)) begin
				resp_credit  <= 1'b1;
				grants_given = grants_given + 1;
			end
		end
	endtask

	task automatic send_req(req_kind_e kind, mem_addr_u addr, logic [7:0] wdata,
			logic [7:0] exp_data);
		tick();
		while (credits_held == 0)
			tick();
		req_valid    <= 1'b1;
		req_kind     <= kind;
		req_addr     <= addr;
		req_wdata    <= wdata;
		credits_held = credits_held - 1;
		req_sent     = req_sent + 1;
		if (kind == req_read) begin
			exp_q.push_back(exp_data);
			reads_sent = reads_sent + 1;
		end
	endtask

	task automatic write_ram(int ram_ofs, logic [7:0] data);
		if (!ram_model.exists(ram_ofs))
			ram_list.push_back(ram_ofs);
		ram_model[ram_ofs] = data;
		send_req(req_write, ram_addr(ram_ofs), data, 8'h00);
	endtask

	task automatic read_ram(int ram_ofs);
		send_req(req_read, ram_addr(ram_ofs), 8'h00, ram_model[ram_ofs]);
	endtask

	task automatic read_rom(int slot, int byte_ofs);
		send_req(req_read, rom_addr(slot, byte_ofs), 8'h00, rom_byte(cur_master, slot, byte_ofs));
	endtask

	function automatic int pick_ram();
		return ram_list[$urandom % ram_list.size()];
	endfunction

	// reset with a model, loading random words into a bank range
	task automatic apply_reset(machine_model_e m, int first_bank, int last_bank);
		int          b;
		int          n;
		int          k;
		logic [15:0] w;
		tick();
		reset <= 1'b1;
		model <= m;
		repeat (16)
			tick();
		for (b = first_bank; b <= last_bank; b++) begin
			for (n = 0; n < WORDS_PER_BANK; n++) begin
				tick();
				word_ofs[b][n] = $urandom % BANK_WORDS;
				k = b * BANK_WORDS + word_ofs[b][n];
				w = 16'($urandom);
				load_wr   <= 1'b1;
				load_addr <= k[`ROM_WORD_BITS-1:0];
				load_data <= w;
				rom_model[k] = w;
			end
		end
		tick();
		cur_master    = (m == model_master);
		credits_held  = `REQ_DEPTH;
		credit_pulses = 0;
		req_sent      = 0;
		reads_sent    = 0;
		grants_given  = 0;
		reset <= 1'b0;
	endtask

	// every slot, hits from the loaded words, misses anywhere
	task automatic check_rom_map(logic master);
		int s;
		int bank;
		int n;
		for (s = 0; s < 16; s++) begin
			bank = map_slot(master, s);
			if (bank >= 0) begin
				for (n = 0; n < WORDS_PER_BANK; n++) begin
					read_rom(s, word_ofs[bank][n] * 2);
					read_rom(s, word_ofs[bank][n] * 2 + 1);
				end
			end else begin
				read_rom(s, $urandom % (1 << `ROM_OFS_BITS));
				read_rom(s, $urandom % (1 << `ROM_OFS_BITS));
			end
		end
	endtask

	task automatic drain();
		grant_mode = 1;
		tick();
		while (exp_q.size() != 0 || credits_held != `REQ_DEPTH)
			tick();
		repeat (4)
			tick();
	endtask

	task automatic compare_count(string name, int got, int want);
		checks = checks + 1;
		a_count : assert (got == want)
			else begin
				$display("[FAIL] %s got %h expected %h", name, got, want);
				errors = errors + 1;
			end
	endtask

	task automatic finish_test(int num, string name, int err_before);
		if (errors == err_before) begin
			$display("test %0d %s ... ok", num, name);
		end else begin
			tests_failed = tests_failed + 1;
			$display("test %0d %s ... %0d errors", num, name, errors - err_before);
		end
	endtask

	// ========================================================================
	// test sequence
	// ========================================================================

	initial begin
		clk_sys     = 1'b0;
		reset       = 1'b1;
		model       = model_b;
		req_valid   = 1'b0;
		req_kind    = req_read;
		req_addr    = '0;
		req_wdata   = 8'h00;
		load_wr     = 1'b0;
		load_addr   = '0;
		load_data   = 16'h0000;
		resp_credit = 1'b0;
		void'($urandom(32'hfbe36e3c));

		// model b banks 0..3
		err_start = errors;
		apply_reset(model_b, 0, 3);
		check_rom_map(1'b0);
		drain();
		finish_test(1, "rom load and model b map", err_start);

		// master banks 4..13, model b words stay in the array
		err_start = errors;
		apply_reset(model_master, 4, `ROM_BANKS - 1);
		check_rom_map(1'b1);
		drain();
		finish_test(2, "master map", err_start);

		err_start = errors;
		for (i = 0; i < 16; i++)
			write_ram($urandom % `RAM_DEPTH, 8'($urandom));
		for (i = 0; i < 16; i++)
			read_ram(pick_ram());
		// back to back writes, last one wins
		ofs = pick_ram();
		write_ram(ofs, 8'($urandom));
		read_ram(ofs);
		// ram byte sharing the low 18 bits of a rom address
		ofs = word_ofs[7][0] * 2;
		write_ram(9 * (1 << `ROM_OFS_BITS) + ofs, 8'($urandom));
		send_req(req_write, rom_addr(9, ofs), 8'($urandom), 8'h00);
		read_rom(9, ofs);
		read_ram(9 * (1 << `ROM_OFS_BITS) + ofs);
		drain();
		finish_test(3, "ram write then read", err_start);

		// no grants, buffer and queue fill up
		err_start = errors;
		grant_mode = 0;
		i = credit_pulses;
		ofs = resp_seen;
		repeat (`REQ_DEPTH + `RESP_DEPTH)
			read_ram(pick_ram());
		repeat (STALL_CYCLES)
			tick();
		compare_count("resp_valid count", resp_seen - ofs, 0);
		compare_count("req_credit pulses", credit_pulses - i, `RESP_DEPTH);
		compare_count("requester credits", credits_held, 0);
		grant_mode = 1;
		repeat (2)
			read_ram(pick_ram());
		drain();
		finish_test(4, "back-pressure", err_start);

		// mixed traffic, random grants and gaps
		err_start = errors;
		grant_mode = 2;
		for (i = 0; i < 60; i++) begin
			case ($urandom_range(0, 4))
				0, 1:    write_ram($urandom % `RAM_DEPTH, 8'($urandom));
				2, 3:    read_ram(pick_ram());
				default: begin
					ofs = 9 + $urandom_range(0, 6);
					read_rom(ofs, word_ofs[ofs - 2][$urandom % WORDS_PER_BANK] * 2
						+ $urandom_range(0, 1));
				end
			endcase
			if ($urandom_range(0, 3) == 0)
				tick();
		end
		drain();
		compare_count("req_credit pulses", credit_pulses, req_sent);
		compare_count("resp_valid count", resp_seen, reads_sent);
		finish_test(5, "credit conservation", err_start);

		$display("tests 5, failed %0d, checks %0d, errors %0d, cycles %0d",
			tests_failed, checks, errors, cycle_count);
		if (errors == 0 && tests_failed == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+verilog
verilog/mem_map_pkg.sv
verilog/bus_pkg.sv
verilog/req_queue.sv
verilog/rom_bank_map.sv
verilog/beeb_mem_access.sv
verilog/resp_credit_out.sv
verilog/beeb_mem_top.sv
test/tb_beeb_mem.sv

/* run_sim.sh */
#!/bin/sh
# build the memory system testbench with Verilator, run it, scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_beeb_mem --Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_beeb_mem > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
	exit 1
fi

exit 0
